// File: vlog.f
+incdir+.
lc3b_types.sv
cache_way.sv
cache_datapath.sv
cache_control.sv
cache.sv
tb_clock_gen.sv
tb_memory.sv
cache_tb.sv

// File: Makefile
# Verilator build and run for the two-way cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Finished with no errors

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS := $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "Simulation passed" || (echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: cache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cache_tb;
    import lc3b_types::*;

    typedef enum logic [1:0] {op_read, op_write, op_clear_miss, op_reset} tb_op_t;

    typedef struct packed {
        tb_op_t   op;
        lc3b_word addr;
        lc3b_word wdata;
        logic     expect_hit;
    } step_t;

    localparam int RESET_CYCLES = 4;
    localparam int CYCLES_PER_STEP = 40;

    logic          clk;
    logic          hit_count_reset;
    logic          miss_count_reset;
    logic          mem_read;
    logic          mem_write;
    lc3b_word      mem_address;
    lc3b_word      mem_wdata;
    logic          mem_resp;
    lc3b_word      mem_rdata;
    logic          pmem_resp;
    lc3b_line      pmem_rdata;
    logic          pmem_read;
    logic          pmem_write;
    lc3b_pmem_addr pmem_address;
    lc3b_line      pmem_wdata;
    lc3b_word      hit_count;
    lc3b_word      miss_count;
    logic          mem_fault;

    step_t         steps[$];
    logic          table_ready;
    logic [31:0]   lfsr_state;
    lc3b_word      ref_mem [32768];   // CPU view of every word
    lc3b_cache_tag model_tag [2][8];
    logic          model_valid [2][8];
    logic          model_lru [8];
    lc3b_word      model_hits;
    lc3b_word      model_misses;

    tb_clock_gen clock_gen (.clk(clk));

    cache cache_i (
        .clk              (clk),
        .hit_count_reset  (hit_count_reset),
        .miss_count_reset (miss_count_reset),
        .mem_read         (mem_read),
        .mem_write        (mem_write),
        .mem_address      (mem_address),
        .mem_wdata        (mem_wdata),
        .mem_resp         (mem_resp),
        .mem_rdata        (mem_rdata),
        .pmem_resp        (pmem_resp),
        .pmem_rdata       (pmem_rdata),
        .pmem_read        (pmem_read),
        .pmem_write       (pmem_write),
        .pmem_address     (pmem_address),
        .pmem_wdata       (pmem_wdata),
        .hit_count        (hit_count),
        .miss_count       (miss_count)
    );

    tb_memory memory (
        .clk          (clk),
        .reset        (hit_count_reset),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_resp    (pmem_resp),
        .pmem_rdata   (pmem_rdata),
        .fault        (mem_fault)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Run stopped at the first error");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1
    endfunction

    task automatic draw_random_word(output lc3b_word w);
        w = '0;
        for (int b = 0; b < 16; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[14:0], lfsr_state[0]};
        end
    endtask

    task automatic add_step(input tb_op_t op, input lc3b_word addr, input logic expect_hit);
        step_t    s;
        lc3b_word w;
        w = '0;
        if (op == op_write) begin
            draw_random_word(w);
        end
        s.op = op;
        s.addr = addr;
        s.wdata = w;
        s.expect_hit = expect_hit;
        steps.push_back(s);
    endtask

    task automatic check_value(input string name, input lc3b_word got, input lc3b_word exp);
        assert (got === exp)
        else abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_counters();
        check_value("hit_count", hit_count, model_hits);
        check_value("miss_count", miss_count, model_misses);
    endtask

    task automatic model_reset();
        for (int s = 0; s < 8; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_lru[s] = 1'b0;
        end
        model_hits = '0;
        model_misses = '0;
    endtask

    // Tag and LRU model; a miss fills the LRU way and then finishes as a hit
    task automatic model_access(input lc3b_word addr, input logic is_write,
                                input lc3b_word data, output logic hit);
        int            set_idx;
        int            way;
        lc3b_cache_tag tag;
        set_idx = int'(addr[6:4]);
        tag = addr[15:7];
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < 2; w++) begin
            if (model_valid[w][set_idx] && model_tag[w][set_idx] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            way = int'(model_lru[set_idx]);
            model_valid[way][set_idx] = 1'b1;
            model_tag[way][set_idx] = tag;
            model_misses = model_misses + 16'd1;
        end
        model_lru[set_idx] = (way == 0);   // Points at the other way
        model_hits = model_hits + 16'd1;
        if (is_write) begin
            ref_mem[addr[15:1]] = data;
        end
    endtask

    task automatic hold_reset();
        @(posedge clk);
        hit_count_reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        hit_count_reset <= 1'b0;
        @(negedge clk);
        model_reset();
        assert (mem_resp === 1'b0 && pmem_read === 1'b0 && pmem_write === 1'b0)
        else abort_run("Cache drives a response or a memory strobe while idle after reset");
        check_counters();
    endtask

    task automatic clear_miss_count();
        @(posedge clk);
        miss_count_reset <= 1'b1;
        @(posedge clk);
        miss_count_reset <= 1'b0;
        @(negedge clk);
        model_misses = '0;
        check_counters();
    endtask

    task automatic run_access(input step_t step, input int idx);
        lc3b_word expected;
        logic     model_hit;
        int       cycles;
        expected = ref_mem[step.addr[15:1]];
        @(posedge clk);
        mem_read <= (step.op == op_read);
        mem_write <= (step.op == op_write);
        mem_address <= step.addr;
        mem_wdata <= step.wdata;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (mem_resp !== 1'b1);
        if (step.op == op_read) begin
            check_value("mem_rdata", mem_rdata, expected);
        end
        model_access(step.addr, step.op == op_write, step.wdata, model_hit);
        assert (model_hit == step.expect_hit)
        else abort_run($sformatf("Stimulus entry %0d disagrees with the reference model", idx));
        assert ((cycles == 1) == step.expect_hit)
        else abort_run($sformatf("Mismatch mem_resp hit at entry %0d: got %h, expected %h",
                                 idx, cycles == 1, step.expect_hit));
        @(posedge clk);
        mem_read <= 1'b0;
        mem_write <= 1'b0;
        @(negedge clk);
        check_counters();
    endtask

    task automatic build_table();
        add_step(op_read,  16'h0010, 1'b0);   // Read miss, set 1
        add_step(op_write, 16'h0012, 1'b1);
        add_step(op_read,  16'h0012, 1'b1);
        add_step(op_write, 16'h0024, 1'b0);   // Dirty line in set 2
        add_step(op_read,  16'h00a0, 1'b0);
        add_step(op_read,  16'h0120, 1'b0);   // Evicts the dirty line
        add_step(op_read,  16'h0024, 1'b0);
        add_step(op_read,  16'h0030, 1'b0);   // A, B, A, C in set 3
        add_step(op_read,  16'h00b0, 1'b0);
        add_step(op_read,  16'h0030, 1'b1);
        add_step(op_read,  16'h0130, 1'b0);
        add_step(op_read,  16'h0030, 1'b1);
        add_step(op_read,  16'h00b0, 1'b0);
        add_step(op_clear_miss, 16'h0000, 1'b0);
        add_step(op_read,  16'h0016, 1'b1);
        add_step(op_write, 16'h00b2, 1'b1);
        add_step(op_write, 16'h0044, 1'b0);
        add_step(op_read,  16'h0044, 1'b1);
        add_step(op_reset, 16'h0000, 1'b0);
        add_step(op_read,  16'h0016, 1'b0);   // Set 1 line was valid before reset
        add_step(op_read,  16'h0250, 1'b0);   // Lines untouched before reset
        add_step(op_write, 16'h0c56, 1'b0);
        add_step(op_read,  16'h0c56, 1'b1);
        add_step(op_read,  16'h0254, 1'b1);
    endtask

    always @(negedge clk) begin
        assert (mem_fault !== 1'b1)
        else abort_run("Physical memory model saw an illegal access");
    end

    initial begin
        wait (table_ready === 1'b1);
        repeat (steps.size() * CYCLES_PER_STEP + RESET_CYCLES) @(posedge clk);
        abort_run("Timeout while waiting for the cache to finish the stimulus table");
    end

    initial begin
        table_ready = 1'b0;
        hit_count_reset = 1'b1;
        miss_count_reset = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_address = '0;
        mem_wdata = '0;
        lfsr_state = 32'hb7d2;
        for (int i = 0; i < 32768; i++) begin
            ref_mem[i] = lc3b_word'(i << 1) ^ 16'h5a5a;
        end
        build_table();
        table_ready = 1'b1;
        hold_reset();
        foreach (steps[i]) begin
            case (steps[i].op)
                op_clear_miss: clear_miss_count();
                op_reset:      hold_reset();
                default:       run_access(steps[i], i);
            endcase
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule : cache_tb

`default_nettype wire

// File: tb_memory.sv
`timescale 1ns/10ps
`default_nettype none

module tb_memory (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       pmem_read,
    input  wire logic                       pmem_write,
    input  wire lc3b_types::lc3b_pmem_addr  pmem_address,
    input  wire lc3b_types::lc3b_line       pmem_wdata,
    output logic                            pmem_resp,
    output lc3b_types::lc3b_line            pmem_rdata,
    output logic                            fault
);
    import lc3b_types::*;

    localparam int WORDS = 16384;   // 32 KiB
    localparam int DELAY = 3;

    lc3b_word    mem [WORDS];
    int          wait_count;
    logic [13:0] base;

    assign base = {pmem_address[14:4], 3'b000};   // First word of the line

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = lc3b_word'(i * 2) ^ 16'h5a5a;
        end
        pmem_resp = 1'b0;
        pmem_rdata = '0;
        fault = 1'b0;
        wait_count = 0;
    end

    always @(posedge clk) begin
        if (reset) begin
            pmem_resp <= 1'b0;
            wait_count <= 0;
        end else if (pmem_resp) begin
            pmem_resp <= 1'b0;   // One cycle pulse
        end else if (pmem_read || pmem_write) begin
            if (wait_count == DELAY - 1) begin
                wait_count <= 0;
                pmem_resp <= 1'b1;
                for (int k = 0; k < 8; k++) begin
                    if (pmem_read) begin
                        pmem_rdata[k*16 +: 16] <= mem[base + k];
                    end else begin
                        mem[base + k] <= pmem_wdata[k*16 +: 16];
                    end
                end
            end else begin
                wait_count <= wait_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && pmem_read && pmem_write) begin
            $display("Physical memory saw read and write strobes high together");
            fault <= 1'b1;
        end
        if (!reset && (pmem_read || pmem_write) && pmem_address[3:0] != 4'h0) begin
            $display("Physical memory address %h is not line aligned", pmem_address);
            fault <= 1'b1;
        end
        if (!reset && (pmem_read || pmem_write) && pmem_address[15]) begin
            $display("Physical memory address %h lies outside the 32 KiB array", pmem_address);
            fault <= 1'b1;
        end
    end

endmodule : tb_memory

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;   // Free running
    end

endmodule : tb_clock_gen

`default_nettype wire

// File: cache.sv
`timescale 1ns/10ps
`default_nettype none

module cache (
    input  wire logic                    clk,
    input  wire logic                    hit_count_reset,
    input  wire logic                    miss_count_reset,
    input  wire logic                    mem_read,
    input  wire logic                    mem_write,
    input  wire lc3b_types::lc3b_word    mem_address,
    input  wire lc3b_types::lc3b_word    mem_wdata,
    output logic                         mem_resp,
    output lc3b_types::lc3b_word         mem_rdata,
    input  wire logic                    pmem_resp,
    input  wire lc3b_types::lc3b_line    pmem_rdata,
    output logic                         pmem_read,
    output logic                         pmem_write,
    output lc3b_types::lc3b_pmem_addr    pmem_address,
    output lc3b_types::lc3b_line         pmem_wdata,
    output lc3b_types::lc3b_word         hit_count,
    output lc3b_types::lc3b_word         miss_count
);
    import lc3b_types::*;

    logic          load_set_one;
    logic          load_set_two;
    logic          load_lru;
    logic          cache_in_mux_sel;
    logic          write_type_set_one;
    logic          write_type_set_two;
    logic          insert_mux_sel;
    logic          pmem_w_mux_sel;
    logic          set_one_hit;
    logic          set_two_hit;
    logic          current_lru;
    logic          set_one_dirty;
    logic          set_two_dirty;
    lc3b_cache_tag set_one_tag;
    lc3b_cache_tag set_two_tag;

    cache_control control (
        .clk                (clk),
        .hit_count_reset    (hit_count_reset),
        .miss_count_reset   (miss_count_reset),
        .mem_read           (mem_read),
        .mem_write          (mem_write),
        .mem_address        (mem_address),
        .mem_resp           (mem_resp),
        .pmem_resp          (pmem_resp),
        .pmem_read          (pmem_read),
        .pmem_write         (pmem_write),
        .pmem_address       (pmem_address),
        .set_one_hit        (set_one_hit),
        .set_two_hit        (set_two_hit),
        .current_lru        (current_lru),
        .set_one_dirty      (set_one_dirty),
        .set_two_dirty      (set_two_dirty),
        .set_one_tag        (set_one_tag),
        .set_two_tag        (set_two_tag),
        .load_set_one       (load_set_one),
        .load_set_two       (load_set_two),
        .load_lru           (load_lru),
        .cache_in_mux_sel   (cache_in_mux_sel),
        .write_type_set_one (write_type_set_one),
        .write_type_set_two (write_type_set_two),
        .insert_mux_sel     (insert_mux_sel),
        .pmem_w_mux_sel     (pmem_w_mux_sel),
        .hit_count          (hit_count),
        .miss_count         (miss_count)
    );

    cache_datapath datapath (
        .clk                (clk),
        .hit_count_reset    (hit_count_reset),
        .mem_address        (mem_address),
        .mem_wdata          (mem_wdata),
        .pmem_rdata         (pmem_rdata),
        .load_set_one       (load_set_one),
        .load_set_two       (load_set_two),
        .load_lru           (load_lru),
        .cache_in_mux_sel   (cache_in_mux_sel),
        .write_type_set_one (write_type_set_one),
        .write_type_set_two (write_type_set_two),
        .insert_mux_sel     (insert_mux_sel),
        .pmem_w_mux_sel     (pmem_w_mux_sel),
        .mem_rdata          (mem_rdata),
        .pmem_wdata         (pmem_wdata),
        .set_one_hit        (set_one_hit),
        .set_two_hit        (set_two_hit),
        .current_lru        (current_lru),
        .set_one_dirty      (set_one_dirty),
        .set_two_dirty      (set_two_dirty),
        .set_one_tag        (set_one_tag),
        .set_two_tag        (set_two_tag)
    );

endmodule : cache

`default_nettype wire

// File: cache_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module cache_control (
    input  wire logic                       clk,
    input  wire logic                       hit_count_reset,
    input  wire logic                       miss_count_reset,
    input  wire logic                       mem_read,
    input  wire logic                       mem_write,
    input  wire lc3b_types::lc3b_word       mem_address,
    output logic                            mem_resp,
    input  wire logic                       pmem_resp,
    output logic                            pmem_read,
    output logic                            pmem_write,
    output lc3b_types::lc3b_pmem_addr       pmem_address,
    input  wire logic                       set_one_hit,
    input  wire logic                       set_two_hit,
    input  wire logic                       current_lru,
    input  wire logic                       set_one_dirty,
    input  wire logic                       set_two_dirty,
    input  wire lc3b_types::lc3b_cache_tag  set_one_tag,
    input  wire lc3b_types::lc3b_cache_tag  set_two_tag,
    output logic                            load_set_one,
    output logic                            load_set_two,
    output logic                            load_lru,
    output logic                            cache_in_mux_sel,
    output logic                            write_type_set_one,
    output logic                            write_type_set_two,
    output logic                            insert_mux_sel,
    output logic                            pmem_w_mux_sel,
    output lc3b_types::lc3b_word            hit_count,
    output lc3b_types::lc3b_word            miss_count
);
    import lc3b_types::*;

    cache_state_t  state;
    cache_state_t  next_state;
    logic          hit;
    logic          request;
    logic          victim_dirty;
    logic          count_hit;
    logic          count_miss;
    lc3b_cache_tag victim_tag;
    lc3b_set_index req_index;

    assign hit = set_one_hit | set_two_hit;
    assign request = mem_read | mem_write;
    assign victim_dirty = current_lru ? set_two_dirty : set_one_dirty;   // LRU 0 picks way one
    assign victim_tag = current_lru ? set_two_tag : set_one_tag;
    assign req_index = mem_address[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];

    always_ff @(posedge clk) begin
        if (hit_count_reset) begin
            state <= hit_s;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_count_reset) begin
            hit_count <= '0;
        end else if (count_hit) begin
            hit_count <= hit_count + 1'b1;   // Wraps
        end
    end

    always_ff @(posedge clk) begin
        if (hit_count_reset || miss_count_reset) begin
            miss_count <= '0;
        end else if (count_miss) begin
            miss_count <= miss_count + 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            hit_s: begin
                if (request && !hit) begin
                    next_state = victim_dirty ? write_back_s : fetch_s;
                end
            end
            write_back_s: begin
                if (pmem_resp) begin
                    next_state = fetch_s;
                end
            end
            fetch_s: begin
                if (pmem_resp) begin
                    next_state = write_s;
                end
            end
            write_s: begin
                next_state = hit_s;   // Held request hits on return
            end
            default: begin
                next_state = hit_s;
            end
        endcase
    end

    always_comb begin
        mem_resp = 1'b0;
        pmem_read = 1'b0;
        pmem_write = 1'b0;
        load_set_one = 1'b0;
        load_set_two = 1'b0;
        load_lru = 1'b0;
        cache_in_mux_sel = 1'b0;
        write_type_set_one = 1'b0;
        write_type_set_two = 1'b0;
        insert_mux_sel = 1'b0;
        pmem_w_mux_sel = 1'b0;
        count_hit = 1'b0;
        count_miss = 1'b0;
        pmem_address = {mem_address[`CACHE_WORD_BITS-1:`CACHE_OFFSET_BITS],
                        {`CACHE_OFFSET_BITS{1'b0}}};
        case (state)
            hit_s: begin
                if (request && hit) begin
                    mem_resp = 1'b1;
                    load_lru = 1'b1;
                    count_hit = 1'b1;
                    if (mem_write) begin
                        load_set_one = set_one_hit;
                        load_set_two = set_two_hit;
                        write_type_set_one = set_one_hit;   // Line becomes dirty
                        write_type_set_two = set_two_hit;
                        cache_in_mux_sel = 1'b1;
                    end
                end
            end
            fetch_s: begin
                pmem_read = 1'b1;
            end
            write_back_s: begin
                pmem_write = 1'b1;
                pmem_w_mux_sel = current_lru;
                pmem_address = {victim_tag, req_index, {`CACHE_OFFSET_BITS{1'b0}}};
            end
            write_s: begin
                load_set_one = ~current_lru;
                load_set_two = current_lru;
                insert_mux_sel = 1'b1;
                cache_in_mux_sel = mem_write;   // Write miss merges into fetched line
                write_type_set_one = mem_write & ~current_lru;
                write_type_set_two = mem_write & current_lru;
                count_miss = 1'b1;
            end
            default: begin
                mem_resp = 1'b0;
            end
        endcase
    end

    // Memory strobes are mutually exclusive
    a_strobe_exclusive: assert property (@(posedge clk) disable iff (hit_count_reset)
        !(pmem_read && pmem_write));

    // A response only completes from the hit state
    a_resp_in_hit: assert property (@(posedge clk) disable iff (hit_count_reset)
        mem_resp |-> (state == hit_s));

    a_state_legal: assert property (@(posedge clk) disable iff (hit_count_reset)
        !$isunknown(state) && (state inside {hit_s, fetch_s, write_back_s, write_s}));

endmodule : cache_control

`default_nettype wire

// File: cache_datapath.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module cache_datapath (
    input  wire logic                       clk,
    input  wire logic                       hit_count_reset,
    input  wire lc3b_types::lc3b_word       mem_address,
    input  wire lc3b_types::lc3b_word       mem_wdata,
    input  wire lc3b_types::lc3b_line       pmem_rdata,
    input  wire logic                       load_set_one,
    input  wire logic                       load_set_two,
    input  wire logic                       load_lru,
    input  wire logic                       cache_in_mux_sel,
    input  wire logic                       write_type_set_one,
    input  wire logic                       write_type_set_two,
    input  wire logic                       insert_mux_sel,
    input  wire logic                       pmem_w_mux_sel,
    output lc3b_types::lc3b_word            mem_rdata,
    output lc3b_types::lc3b_line            pmem_wdata,
    output logic                            set_one_hit,
    output logic                            set_two_hit,
    output logic                            current_lru,
    output logic                            set_one_dirty,
    output logic                            set_two_dirty,
    output lc3b_types::lc3b_cache_tag       set_one_tag,
    output lc3b_types::lc3b_cache_tag       set_two_tag
);
    import lc3b_types::*;

    lc3b_cache_tag                  req_tag;
    lc3b_set_index                  req_index;
    logic [`CACHE_OFFSET_BITS-2:0]  word_sel;
    logic [`CACHE_SETS-1:0]         lru_q;
    lc3b_line                       line_one;
    lc3b_line                       line_two;
    lc3b_line                       hit_line;

    assign req_tag = mem_address[`CACHE_WORD_BITS-1 -: `CACHE_TAG_BITS];
    assign req_index = mem_address[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
    assign word_sel = mem_address[`CACHE_OFFSET_BITS-1:1];

    cache_way way_one (
        .clk             (clk),
        .hit_count_reset (hit_count_reset),
        .load            (load_set_one),
        .dirty_in        (write_type_set_one),
        .insert          (insert_mux_sel),
        .word_write      (cache_in_mux_sel),
        .index           (req_index),
        .offset          (mem_address),
        .tag_in          (req_tag),
        .wdata           (mem_wdata),
        .line_in         (pmem_rdata),
        .hit             (set_one_hit),
        .dirty           (set_one_dirty),
        .tag_out         (set_one_tag),
        .line_out        (line_one)
    );

    cache_way way_two (
        .clk             (clk),
        .hit_count_reset (hit_count_reset),
        .load            (load_set_two),
        .dirty_in        (write_type_set_two),
        .insert          (insert_mux_sel),
        .word_write      (cache_in_mux_sel),
        .index           (req_index),
        .offset          (mem_address),
        .tag_in          (req_tag),
        .wdata           (mem_wdata),
        .line_in         (pmem_rdata),
        .hit             (set_two_hit),
        .dirty           (set_two_dirty),
        .tag_out         (set_two_tag),
        .line_out        (line_two)
    );

    // LRU bit names the victim way, 0 for way one
    always_ff @(posedge clk) begin
        if (hit_count_reset) begin
            lru_q <= '0;
        end else if (load_lru) begin
            lru_q[req_index] <= set_one_hit;   // Point at the way not used
        end
    end

    assign current_lru = lru_q[req_index];

    assign hit_line = set_two_hit ? line_two : line_one;
    assign mem_rdata = hit_line[word_sel*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];
    assign pmem_wdata = pmem_w_mux_sel ? line_two : line_one;   // Victim line

    // A tag may live in only one way of a set
    a_single_way_hit: assert property (@(posedge clk) disable iff (hit_count_reset)
        !(set_one_hit && set_two_hit));

endmodule : cache_datapath

`default_nettype wire

// File: cache_way.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module cache_way (
    input  wire logic                       clk,
    input  wire logic                       hit_count_reset,
    input  wire logic                       load,
    input  wire logic                       dirty_in,
    input  wire logic                       insert,
    input  wire logic                       word_write,
    input  wire lc3b_types::lc3b_set_index  index,
    input  wire lc3b_types::lc3b_word       offset,
    input  wire lc3b_types::lc3b_cache_tag  tag_in,
    input  wire lc3b_types::lc3b_word       wdata,
    input  wire lc3b_types::lc3b_line       line_in,
    output logic                            hit,
    output logic                            dirty,
    output lc3b_types::lc3b_cache_tag       tag_out,
    output lc3b_types::lc3b_line            line_out
);
    import lc3b_types::*;

    localparam int WORD_SEL_BITS = `CACHE_OFFSET_BITS - 1;

    lc3b_cache_tag            tag_mem [`CACHE_SETS];
    lc3b_line                 line_mem [`CACHE_SETS];
    logic [`CACHE_SETS-1:0]   valid_q;
    logic [`CACHE_SETS-1:0]   dirty_q;
    logic [WORD_SEL_BITS-1:0] word_sel;
    lc3b_line                 line_next;

    assign word_sel = offset[`CACHE_OFFSET_BITS-1:1];   // Word inside the line
    assign tag_out = tag_mem[index];
    assign line_out = line_mem[index];
    assign dirty = dirty_q[index];
    assign hit = valid_q[index] && (tag_mem[index] == tag_in);

    // Fetched line or current line, then optional word merge
    always_comb begin
        line_next = insert ? line_in : line_mem[index];
        if (word_write) begin
            line_next[word_sel*`CACHE_WORD_BITS +: `CACHE_WORD_BITS] = wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_count_reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (load) begin
            valid_q[index] <= 1'b1;
            if (insert) begin
                dirty_q[index] <= dirty_in;   // Fresh line starts clean unless written
            end else begin
                dirty_q[index] <= dirty_q[index] | dirty_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            line_mem[index] <= line_next;
            if (insert) begin
                tag_mem[index] <= tag_in;
            end
        end
    end

endmodule : cache_way

`default_nettype wire

// File: lc3b_types.sv
`default_nettype none

`include "cache_consts.svh"

package lc3b_types;

    typedef logic [`CACHE_WORD_BITS-1:0] lc3b_word;        // CPU data word or byte address
    typedef logic [`CACHE_WORD_BITS-1:0] lc3b_pmem_addr;   // Line aligned
    typedef logic [`CACHE_TAG_BITS-1:0] lc3b_cache_tag;
    typedef logic [`CACHE_INDEX_BITS-1:0] lc3b_set_index;
    typedef logic [`CACHE_LINE_BITS-1:0] lc3b_line;

    // Controller states
    typedef enum logic [1:0] {
        hit_s,
        fetch_s,
        write_back_s,
        write_s
    } cache_state_t;

endpackage : lc3b_types

`default_nettype wire

// File: cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Two-way cache geometry for 16-bit LC-3b byte addresses
// Address split is tag[15:7], set index[6:4], byte offset[3:0]

// Sets per way
`define CACHE_SETS 8

// Set index width
`define CACHE_INDEX_BITS 3

// Byte offset inside a 16-byte line
`define CACHE_OFFSET_BITS 4

// Tag width
`define CACHE_TAG_BITS 9

// Line and word widths
`define CACHE_LINE_BITS 128
`define CACHE_WORD_BITS 16

`endif
